// File: Makefile
TOP = cordic_rotator_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 -f cordic_rotator.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: cordic_rotator.f
design/cordic_fmt_pkg.sv
design/cordic_tables_pkg.sv
design/cordic_if.sv
design/cordic_range_reduce.sv
design/cordic_rotate_stage.sv
design/cordic_gain_comp.sv
design/cordic_rotator.sv
test/cordic_rotator_assert.sv
test/cordic_rotator_tb.sv

// File: design/cordic_fmt_pkg.sv
package cordic_fmt_pkg;

    // vector components at the ports, Q2.30
    localparam int SAMPLE_W    = 32;
    localparam int SAMPLE_FRAC = 30;

    // extra integer bits carried between stages
    localparam int GUARD_W     = 2;

    // angles in radians, Q4.28
    localparam int ANGLE_W     = 32;
    localparam int ANGLE_FRAC  = 28;

    typedef logic signed [SAMPLE_W-1:0]         sample_t;  // port component
    typedef logic signed [SAMPLE_W+GUARD_W-1:0] state_t;   // Q4.30 inside the pipe
    typedef logic signed [ANGLE_W-1:0]          angle_t;   // valid range -2pi .. 2pi

endpackage

// File: design/cordic_gain_comp.sv
`timescale 1ns/1ns

module cordic_gain_comp (
    input  logic                    i_clk,
    input  logic                    i_reset,
    cordic_vec_if.dst               i_in,
    output logic                    o_valid,
    output cordic_fmt_pkg::sample_t o_x,
    output cordic_fmt_pkg::sample_t o_y
);

    localparam int STEPS = cordic_tables_pkg::GAIN_STEPS;

    cordic_fmt_pkg::state_t x_in  [STEPS];    // input of each factor stage
    cordic_fmt_pkg::state_t y_in  [STEPS];
    cordic_fmt_pkg::state_t x_sum [STEPS];    // x * factor
    cordic_fmt_pkg::state_t y_sum [STEPS];
    cordic_fmt_pkg::state_t x_q   [STEPS-1];  // registers between factor stages
    cordic_fmt_pkg::state_t y_q   [STEPS-1];
    logic [STEPS-2:0]       valid_q;
    logic [STEPS-2:0]       neg_q;

    for (genvar k = 0; k < STEPS; k++) begin : g_step
        if (k == 0) begin : g_half
            assign x_in[k] = i_in.x >>> 1;  // the 1/2 factor rides along
            assign y_in[k] = i_in.y >>> 1;
        end else begin : g_chain
            assign x_in[k] = x_q[k-1];
            assign y_in[k] = y_q[k-1];
        end

        if (cordic_tables_pkg::GAIN_SUB[k]) begin : g_sub
            assign x_sum[k] = x_in[k] - (x_in[k] >>> cordic_tables_pkg::GAIN_SHIFT[k]);
            assign y_sum[k] = y_in[k] - (y_in[k] >>> cordic_tables_pkg::GAIN_SHIFT[k]);
        end else begin : g_add
            assign x_sum[k] = x_in[k] + (x_in[k] >>> cordic_tables_pkg::GAIN_SHIFT[k]);
            assign y_sum[k] = y_in[k] + (y_in[k] >>> cordic_tables_pkg::GAIN_SHIFT[k]);
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            x_q     <= '{default: '0};
            y_q     <= '{default: '0};
            valid_q <= '0;
            neg_q   <= '0;
            o_valid <= 1'b0;
            o_x     <= '0;
            o_y     <= '0;
        end else begin
            for (int k = 0; k < STEPS-1; k++) begin
                x_q[k] <= x_sum[k];
                y_q[k] <= y_sum[k];
            end
            valid_q <= {valid_q[STEPS-3:0], i_in.valid};
            neg_q   <= {neg_q[STEPS-3:0], i_in.neg};
            // last factor stage, fold back and drop guard bits
            o_valid <= valid_q[STEPS-2];
            o_x     <= cordic_fmt_pkg::sample_t'(neg_q[STEPS-2] ? -x_sum[STEPS-1] : x_sum[STEPS-1]);
            o_y     <= cordic_fmt_pkg::sample_t'(neg_q[STEPS-2] ? -y_sum[STEPS-1] : y_sum[STEPS-1]);
        end
    end

endmodule

// File: design/cordic_if.sv
`timescale 1ns/1ns

// one item between rotation stages
interface cordic_rot_if;

    logic                   valid;
    cordic_fmt_pkg::state_t x;
    cordic_fmt_pkg::state_t y;
    cordic_fmt_pkg::angle_t z;    // residual angle
    logic                   neg;  // negate at the very end

    modport src (output valid, output x, output y, output z, output neg);
    modport dst (input valid, input x, input y, input z, input neg);

endinterface

// rotated vector on its way into gain compensation
interface cordic_vec_if;

    logic                   valid;
    cordic_fmt_pkg::state_t x;
    cordic_fmt_pkg::state_t y;
    logic                   neg;

    modport src (output valid, output x, output y, output neg);
    modport dst (input valid, input x, input y, input neg);

endinterface

// File: design/cordic_range_reduce.sv
`timescale 1ns/1ns

module cordic_range_reduce (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  cordic_fmt_pkg::sample_t i_x,
    input  cordic_fmt_pkg::sample_t i_y,
    input  cordic_fmt_pkg::angle_t  i_z,
    cordic_rot_if.src               o_out
);

    cordic_fmt_pkg::angle_t z_wrap;  // folded into 0 .. 2pi
    cordic_fmt_pkg::angle_t z_fold;  // folded into -pi/2 .. pi/2
    logic                   neg_fold;

    always_comb begin
        if (i_z < 0) begin
            z_wrap = i_z + cordic_tables_pkg::TWO_PI;
        end else begin
            z_wrap = i_z;
        end

        neg_fold = 1'b0;
        if (z_wrap >= cordic_tables_pkg::PI_3HALF) begin
            z_fold = z_wrap - cordic_tables_pkg::TWO_PI;  // fourth quadrant
        end else if (z_wrap > cordic_tables_pkg::PI_HALF) begin
            // rotate by z - pi and flip the result
            z_fold   = z_wrap - cordic_tables_pkg::PI;
            neg_fold = 1'b1;
        end else begin
            z_fold = z_wrap;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_out.valid <= 1'b0;
            o_out.x     <= '0;
            o_out.y     <= '0;
            o_out.z     <= '0;
            o_out.neg   <= 1'b0;
        end else begin
            o_out.valid <= i_valid;
            o_out.x     <= cordic_fmt_pkg::state_t'(i_x);  // sign extend into guard bits
            o_out.y     <= cordic_fmt_pkg::state_t'(i_y);
            o_out.z     <= z_fold;
            o_out.neg   <= neg_fold;
        end
    end

endmodule

// File: design/cordic_rotate_stage.sv
`timescale 1ns/1ns

module cordic_rotate_stage #(
    parameter int STAGE = 0  // iteration index, shift amount
) (
    input  logic      i_clk,
    input  logic      i_reset,
    cordic_rot_if.dst i_in,
    cordic_rot_if.src o_out
);

    cordic_fmt_pkg::state_t x_shift;
    cordic_fmt_pkg::state_t y_shift;
    logic                   rot_neg;  // residual angle below zero

    assign x_shift = i_in.x >>> STAGE;
    assign y_shift = i_in.y >>> STAGE;
    assign rot_neg = i_in.z[cordic_fmt_pkg::ANGLE_W-1];

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_out.valid <= 1'b0;
            o_out.x     <= '0;
            o_out.y     <= '0;
            o_out.z     <= '0;
            o_out.neg   <= 1'b0;
        end else begin
            o_out.valid <= i_in.valid;
            o_out.neg   <= i_in.neg;
            if (rot_neg) begin  // clockwise
                o_out.x <= i_in.x + y_shift;
                o_out.y <= i_in.y - x_shift;
                o_out.z <= i_in.z + cordic_tables_pkg::ATAN_TABLE[STAGE];
            end else begin      // counter-clockwise
                o_out.x <= i_in.x - y_shift;
                o_out.y <= i_in.y + x_shift;
                o_out.z <= i_in.z - cordic_tables_pkg::ATAN_TABLE[STAGE];
            end
        end
    end

endmodule

// File: design/cordic_rotator.sv
`timescale 1ns/1ns

module cordic_rotator #(
    parameter int N_ITER = 16  // 12 .. MAX_ITER micro-rotations
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  cordic_fmt_pkg::sample_t i_x,
    input  cordic_fmt_pkg::sample_t i_y,
    input  cordic_fmt_pkg::angle_t  i_z,
    output logic                    o_valid,
    output cordic_fmt_pkg::sample_t o_x,
    output cordic_fmt_pkg::sample_t o_y
);

    // rot_bus[0] leaves range reduction, rot_bus[g+1] leaves stage g
    cordic_rot_if rot_bus [N_ITER+1] ();
    cordic_vec_if vec_bus ();

    cordic_range_reduce cordic_range_reduce_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_z     (i_z),
        .o_out   (rot_bus[0])
    );

    for (genvar g = 0; g < N_ITER; g++) begin : g_rot
        cordic_rotate_stage #(
            .STAGE (g)
        ) cordic_rotate_stage_inst (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_in    (rot_bus[g]),
            .o_out   (rot_bus[g+1])
        );
    end

    // residual angle is spent after the last stage
    assign vec_bus.valid = rot_bus[N_ITER].valid;
    assign vec_bus.x     = rot_bus[N_ITER].x;
    assign vec_bus.y     = rot_bus[N_ITER].y;
    assign vec_bus.neg   = rot_bus[N_ITER].neg;

    cordic_gain_comp cordic_gain_comp_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_in    (vec_bus),
        .o_valid (o_valid),
        .o_x     (o_x),
        .o_y     (o_y)
    );

endmodule

// File: design/cordic_tables_pkg.sv
package cordic_tables_pkg;

    localparam int MAX_ITER = 16;

    // arctan(2^-i) in Q4.28, rounded
    localparam cordic_fmt_pkg::angle_t ATAN_TABLE [MAX_ITER] = '{
        32'h0C90_FDAA,  // 45 deg
        32'h076B_19C1,
        32'h03EB_6EBF,
        32'h01FD_5BAA,
        32'h00FF_AADE,
        32'h007F_F557,
        32'h003F_FEAB,
        32'h001F_FFD5,
        32'h000F_FFFB,
        32'h0007_FFFF,
        32'h0004_0000,  // from here on atan(x) == x at this precision
        32'h0002_0000,
        32'h0001_0000,
        32'h0000_8000,
        32'h0000_4000,
        32'h0000_2000
    };

    // 0.5 * (1+2^-3)(1+2^-4)(1+2^-6)(1+2^-9)(1-2^-10)(1-2^-11)(1-2^-14) ~ 0.60725
    localparam int GAIN_STEPS = 7;
    localparam int GAIN_SHIFT [GAIN_STEPS] = '{3, 4, 6, 9, 10, 11, 14};
    localparam logic [GAIN_STEPS-1:0] GAIN_SUB = 7'b111_0000;  // bit k set = subtract

    // range reduction bounds
    localparam cordic_fmt_pkg::angle_t PI_HALF  = 32'h1921_FB54;
    localparam cordic_fmt_pkg::angle_t PI       = 32'h3243_F6A9;
    localparam cordic_fmt_pkg::angle_t PI_3HALF = 32'h4B65_F1FD;
    localparam cordic_fmt_pkg::angle_t TWO_PI   = 32'h6487_ED51;

endpackage

// File: test/cordic_rotator_assert.sv
`timescale 1ns/1ns

module cordic_rotator_assert (
    input logic i_clk,
    input logic i_reset,
    input logic i_valid,
    input logic o_valid
);

    localparam int LATENCY = 24;  // sampling edge to o_valid

    a_quiet_in_reset : assert property (@(posedge i_clk) !i_reset |-> !o_valid)
        else $error("o_valid high while reset is held");

    a_known : assert property (@(posedge i_clk) disable iff (!i_reset) !$isunknown(o_valid))
        else $error("o_valid unknown out of reset");

    // every strobe comes out, and nothing else does
    a_strobe_out : assert property (@(posedge i_clk) disable iff (!i_reset)
        i_valid |-> ##LATENCY o_valid)
        else $error("o_valid missing after an input strobe");

    a_strobe_in : assert property (@(posedge i_clk) disable iff (!i_reset)
        o_valid |-> $past(i_valid, LATENCY))
        else $error("o_valid without a matching input strobe");

endmodule

bind cordic_rotator cordic_rotator_assert cordic_rotator_assert_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .o_valid (o_valid)
);

// File: test/cordic_rotator_tb.sv
`timescale 1ns/1ns

module cordic_rotator_tb;

    typedef cordic_fmt_pkg::sample_t sample_t;
    typedef cordic_fmt_pkg::angle_t  angle_t;

    localparam int  LATENCY      = 24;           // cycles from strobe to o_valid
    localparam int  TOL          = 1 << 16;      // 2^-14 in Q2.30
    localparam int  TIMEOUT      = 100;
    localparam real SAMPLE_SCALE = 1073741824.0;  // 2^30
    localparam real ANGLE_SCALE  = 268435456.0;   // 2^28

    typedef struct {
        int      due;  // cycle count when the result shows
        sample_t ex;
        sample_t ey;
        int      tol;
    } expect_t;

    logic    i_clk;
    logic    i_reset;
    logic    i_valid;
    sample_t i_x;
    sample_t i_y;
    angle_t  i_z;
    logic    o_valid;
    sample_t o_x;
    sample_t o_y;

    expect_t     sb [$];  // results still in flight
    int          cyc = 0;
    int          zmax;    // 2pi in Q4.28
    logic [31:0] rng;

    cordic_rotator #(
        .N_ITER (16)
    ) cordic_rotator_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_z     (i_z),
        .o_valid (o_valid),
        .o_x     (o_x),
        .o_y     (o_y)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc <= cyc + 1;

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp,
                                input int tol);
        longint diff;
        diff = longint'(got) - longint'(exp);
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > longint'(tol)) begin
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // exact rotation in real arithmetic
    task automatic rotate_ref(input sample_t x, input sample_t y, input angle_t z,
                              output sample_t ex, output sample_t ey);
        real xr;
        real yr;
        real zr;
        xr = $itor(x) / SAMPLE_SCALE;
        yr = $itor(y) / SAMPLE_SCALE;
        zr = $itor(z) / ANGLE_SCALE;
        ex = sample_t'($rtoi((xr * $cos(zr) - yr * $sin(zr)) * SAMPLE_SCALE));
        ey = sample_t'($rtoi((xr * $sin(zr) + yr * $cos(zr)) * SAMPLE_SCALE));
    endtask

    task automatic drive_item(input sample_t x, input sample_t y, input angle_t z,
                              input sample_t ex, input sample_t ey, input int tol);
        expect_t e;
        @(posedge i_clk);
        #2;
        i_valid = 1'b1;
        i_x     = x;
        i_y     = y;
        i_z     = z;
        e.due   = cyc + LATENCY;
        e.ex    = ex;
        e.ey    = ey;
        e.tol   = tol;
        sb.push_back(e);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            #2;
            i_valid = 1'b0;
        end
    endtask

    task automatic drive_random(input int gap_max);
        sample_t x;
        sample_t y;
        sample_t ex;
        sample_t ey;
        angle_t  z;
        int      gap;
        rng = next_rand(rng);
        x   = sample_t'($signed(rng) >>> 1);  // within +-1.0
        rng = next_rand(rng);
        y   = sample_t'($signed(rng) >>> 1);
        rng = next_rand(rng);
        z   = angle_t'($signed(rng) % zmax);
        rotate_ref(x, y, z, ex, ey);
        drive_item(x, y, z, ex, ey, TOL);
        rng = next_rand(rng);
        gap = int'(rng % (gap_max + 1));
        if (gap > 0) begin
            drive_idle(gap);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sb.size() > 0 && n < TIMEOUT) begin
            @(negedge i_clk);
            n++;
        end
        if (sb.size() > 0) begin
            $display("no result arrived within %0d cycles, %0d still pending", TIMEOUT,
                     sb.size());
            stop_with_failure();
        end
    endtask

    always @(negedge i_clk) begin : monitor
        logic    want;
        expect_t e;
        if (i_reset) begin
            want = (sb.size() > 0) && (sb[0].due == cyc);  // exact latency
            check_flag("o_valid", o_valid, want);
            if (o_valid) begin
                e = sb.pop_front();
                check_sample("o_x", o_x, e.ex, e.tol);
                check_sample("o_y", o_y, e.ey, e.tol);
            end
        end
    end

    initial begin
        string   line;
        int      fd;
        int      cnt;
        int      n_vec;
        sample_t x;
        sample_t y;
        sample_t ex;
        sample_t ey;
        angle_t  z;
        i_reset   = 1'b0;
        i_valid   = 1'b0;
        i_x       = '0;
        i_y       = '0;
        i_z       = '0;
        n_vec     = 0;
        rng       = 32'hbb53_8f26;
        zmax      = $rtoi(2.0 * 3.141592653589793 * ANGLE_SCALE);
        repeat (8) @(posedge i_clk);
        #2;
        i_reset = 1'b1;

        repeat (4) @(negedge i_clk);  // outputs quiet before the first strobe
        check_sample("o_x", o_x, '0, 0);
        check_sample("o_y", o_y, '0, 0);

        fd = $fopen("test/cordic_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file test/cordic_stim.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h", x, y, z, ex, ey);
                if (cnt == 5) begin
                    drive_item(x, y, z, ex, ey, TOL);  // back to back
                    n_vec++;
                end
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("no vectors read from test/cordic_stim.txt");
            stop_with_failure();
        end
        drive_idle(1);
        wait_drain();

        repeat (8) begin  // zero vector stays exactly zero
            rng = next_rand(rng);
            drive_item('0, '0, angle_t'($signed(rng) % zmax), '0, '0, 0);
        end
        drive_idle(1);
        wait_drain();

        repeat (40) drive_random(0);  // more than a full pipe
        drive_idle(1);
        wait_drain();

        repeat (200) drive_random(3);
        drive_idle(1);
        wait_drain();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: test/cordic_stim.txt
# columns: x y z expected_x expected_y, all hex
# x, y and results in Q2.30, z in Q4.28 radians
40000000 00000000 00000000 40000000 00000000
20000000 E0000000 00000000 20000000 E0000000
40000000 00000000 0C90FDAA 2D413CCD 2D413CCD
20000000 20000000 0C90FDAA 00000000 2D413CCD
40000000 00000000 1921FB54 00000000 40000000
40000000 00000000 1921FB55 00000000 40000000
00000000 40000000 1921FB54 C0000000 00000000
40000000 00000000 25B2F8FE D2BEC333 2D413CCD
40000000 00000000 3243F6A9 C0000000 00000000
C0000000 20000000 3243F6A9 40000000 E0000000
40000000 00000000 3ED4F453 D2BEC333 D2BEC333
40000000 00000000 4B65F1FC 00000000 C0000000
40000000 00000000 4B65F1FD 00000000 C0000000
40000000 00000000 57F6EFA7 2D413CCD D2BEC333
40000000 00000000 6487ED51 40000000 00000000
40000000 00000000 9B7812AF 40000000 00000000
40000000 00000000 F36F0256 2D413CCD D2BEC333
40000000 00000000 E6DE04AC 00000000 C0000000
40000000 00000000 DA4D0702 D2BEC333 D2BEC333
40000000 00000000 CDBC0957 C0000000 00000000
00000000 C0000000 F36F0256 D2BEC333 D2BEC333
20000000 00000000 E6DE04AC 00000000 E0000000
